// File: tbuf_pkg.sv
// Shared word and thread types, load and store port FSM states
package tbuf_pkg;

  // One memory word
  typedef logic [31:0] data_t;

  // Thread identifier for a two-thread core
  typedef logic [0:0] thread_t;

  // Load port FSM
  typedef enum logic [1:0] {
    LD_IDLE,
    LD_CHECK,
    LD_BUS,
    LD_DONE
  } load_state_e;

  // Store port FSM
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CHECK,
    ST_BUS,
    ST_ALLOC,
    ST_DONE
  } store_state_e;

endpackage

// File: tbufcam_entry.sv
// Single CAM entry with address, owning thread, free flag and two compare ports
`timescale 1ns/1ps

module tbufcam_entry #(
  parameter int ADDR_W = 11
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                except,
  input  tbuf_pkg::thread_t   except_thread,
  input  logic [ADDR_W-1:0]   new_addr,
  input  tbuf_pkg::thread_t   new_thread,
  input  logic                new_en,
  input  logic [ADDR_W-1:0]   chk_addr0,
  input  logic [ADDR_W-1:0]   chk_addr1,
  output logic                chk_match0,
  output logic                chk_match1,
  output logic                free
);

  logic [ADDR_W-1:0] addr;
  tbuf_pkg::thread_t thread;

  assign chk_match0 = (chk_addr0 == addr) && !free;
  assign chk_match1 = (chk_addr1 == addr) && !free;

  always_ff @(posedge clk) begin
    if (new_en) begin
      addr   <= new_addr;
      thread <= new_thread;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      free <= 1'b1;
    end else if (new_en) begin
      // A flush for the same thread in this cycle wins over the allocation
      free <= except && (except_thread == new_thread);
    end else if (except && (except_thread == thread)) begin
      free <= 1'b1;
    end
  end

endmodule

// File: find_first_set.sv
// Priority finder giving the lowest set bit as one-hot plus an any-set flag
`timescale 1ns/1ps

module find_first_set #(
  parameter int BUF_COUNT = 4
) (
  input  logic [BUF_COUNT-1:0] bits,
  output logic [BUF_COUNT-1:0] first,
  output logic                 any
);

  logic [BUF_COUNT-1:0] seen;

  // seen[i] is high when some bit below i is set
  always_comb begin
    seen[0] = 1'b0;
    for (int i = 1; i < BUF_COUNT; i++) begin
      seen[i] = seen[i-1] | bits[i-1];
    end
  end

  assign first = bits & ~seen;
  assign any   = |bits;

endmodule

// File: tbufcam.sv
// Per-thread address CAM with first-free allocation and match reduction
`timescale 1ns/1ps

module tbufcam #(
  parameter int ADDR_W    = 11,
  parameter int BUF_COUNT = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                except,
  input  tbuf_pkg::thread_t   except_thread,
  input  logic [ADDR_W-1:0]   new_addr,
  input  tbuf_pkg::thread_t   new_thread,
  input  logic                new_en,
  input  logic [ADDR_W-1:0]   chk_addr0,
  input  logic [ADDR_W-1:0]   chk_addr1,
  output logic                chk_match0,
  output logic                chk_match1,
  output logic                free
);

  logic [BUF_COUNT-1:0] bank_free  [2];
  logic [BUF_COUNT-1:0] bank_first [2];
  logic [BUF_COUNT-1:0] bank_en    [2];
  logic                 bank_any   [2];
  logic [BUF_COUNT-1:0] bank_match0 [2];
  logic [BUF_COUNT-1:0] bank_match1 [2];

  for (genvar t = 0; t < 2; t++) begin : g_bank
    // Only the first free entry of the selected bank takes the new address
    assign bank_en[t] = bank_first[t] &
                        {BUF_COUNT{new_en && (new_thread == tbuf_pkg::thread_t'(t))}};

    find_first_set #(.BUF_COUNT(BUF_COUNT)) u_first_free (
      .bits  (bank_free[t]),
      .first (bank_first[t]),
      .any   (bank_any[t])
    );

    for (genvar k = 0; k < BUF_COUNT; k++) begin : g_entry
      tbufcam_entry #(.ADDR_W(ADDR_W)) u_entry (
        .clk           (clk),
        .rst           (rst),
        .except        (except),
        .except_thread (except_thread),
        .new_addr      (new_addr),
        .new_thread    (new_thread),
        .new_en        (bank_en[t][k]),
        .chk_addr0     (chk_addr0),
        .chk_addr1     (chk_addr1),
        .chk_match0    (bank_match0[t][k]),
        .chk_match1    (bank_match1[t][k]),
        .free          (bank_free[t][k])
      );
    end
  end

  // Loads see stores of both threads
  assign chk_match0 = |bank_match0[0] || |bank_match0[1];
  assign chk_match1 = |bank_match1[0] || |bank_match1[1];

  assign free = bank_any[new_thread];

endmodule

// File: store_port.sv
// Store port FSM with Wishbone write master and CAM allocation after the write
`timescale 1ns/1ps

module store_port #(
  parameter int ADDR_W = 11
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                st_req,
  input  logic [ADDR_W-1:0]   st_addr,
  input  tbuf_pkg::data_t     st_data,
  input  tbuf_pkg::thread_t   st_thread,
  input  logic                cam_free,
  input  logic                wb_ack,
  output logic                st_busy,
  output logic                st_done,
  output logic                st_full,
  output logic [ADDR_W-1:0]   cam_new_addr,
  output tbuf_pkg::thread_t   cam_new_thread,
  output logic                cam_new_en,
  output logic                wb_cyc,
  output logic                wb_stb,
  output logic                wb_we,
  output logic [ADDR_W-1:0]   wb_adr,
  output tbuf_pkg::data_t     wb_dat_w
);

  tbuf_pkg::store_state_e state;
  logic [ADDR_W-1:0]      addr_q;
  tbuf_pkg::data_t        data_q;
  tbuf_pkg::thread_t      thread_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= tbuf_pkg::ST_IDLE;
    end else begin
      case (state)
        tbuf_pkg::ST_IDLE:  if (st_req) state <= tbuf_pkg::ST_CHECK;
        // Full bank ends the store without touching memory
        tbuf_pkg::ST_CHECK: state <= cam_free ? tbuf_pkg::ST_BUS : tbuf_pkg::ST_DONE;
        tbuf_pkg::ST_BUS:   if (wb_ack) state <= tbuf_pkg::ST_ALLOC;
        tbuf_pkg::ST_ALLOC: state <= tbuf_pkg::ST_DONE;
        default:            state <= tbuf_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == tbuf_pkg::ST_IDLE && st_req) begin
      addr_q   <= st_addr;
      data_q   <= st_data;
      thread_q <= st_thread;
    end
    if (state == tbuf_pkg::ST_CHECK) st_full <= !cam_free;
  end

  assign st_busy = (state != tbuf_pkg::ST_IDLE);
  assign st_done = (state == tbuf_pkg::ST_DONE);

  // CAM sees the latched request; free is reported for this thread's bank
  assign cam_new_addr   = addr_q;
  assign cam_new_thread = thread_q;
  assign cam_new_en     = (state == tbuf_pkg::ST_ALLOC);

  assign wb_cyc   = (state == tbuf_pkg::ST_BUS);
  assign wb_stb   = wb_cyc;
  assign wb_we    = wb_cyc;
  assign wb_adr   = addr_q;
  assign wb_dat_w = data_q;

endmodule

// File: load_port.sv
// Load port FSM with CAM check, replay and Wishbone read master
`timescale 1ns/1ps

module load_port #(
  parameter int ADDR_W = 11
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                ld_req,
  input  logic [ADDR_W-1:0]   ld_addr,
  input  logic                chk_match,
  input  logic                wb_ack,
  input  tbuf_pkg::data_t     wb_dat_r,
  output logic                ld_busy,
  output logic                ld_done,
  output logic                ld_replay,
  output tbuf_pkg::data_t     ld_data,
  output logic [ADDR_W-1:0]   chk_addr,
  output logic                wb_cyc,
  output logic                wb_stb,
  output logic                wb_we,
  output logic [ADDR_W-1:0]   wb_adr
);

  tbuf_pkg::load_state_e state;
  logic [ADDR_W-1:0]     addr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= tbuf_pkg::LD_IDLE;
    end else begin
      case (state)
        tbuf_pkg::LD_IDLE:  if (ld_req) state <= tbuf_pkg::LD_CHECK;
        tbuf_pkg::LD_CHECK: state <= chk_match ? tbuf_pkg::LD_DONE : tbuf_pkg::LD_BUS;
        tbuf_pkg::LD_BUS:   if (wb_ack) state <= tbuf_pkg::LD_DONE;
        default:            state <= tbuf_pkg::LD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == tbuf_pkg::LD_IDLE && ld_req) addr_q <= ld_addr;
    // Live speculative store on this address, memory not read
    if (state == tbuf_pkg::LD_CHECK && chk_match) begin
      ld_replay <= 1'b1;
      ld_data   <= '0;
    end
    if (state == tbuf_pkg::LD_BUS && wb_ack) begin
      ld_replay <= 1'b0;
      ld_data   <= wb_dat_r;
    end
  end

  assign ld_busy  = (state != tbuf_pkg::LD_IDLE);
  assign ld_done  = (state == tbuf_pkg::LD_DONE);
  assign chk_addr = addr_q;

  assign wb_cyc = (state == tbuf_pkg::LD_BUS);
  assign wb_stb = wb_cyc;
  assign wb_we  = 1'b0;
  assign wb_adr = addr_q;

endmodule

// File: wb_arbiter.sv
// Three-master round-robin Wishbone classic arbiter, grant held for a whole cycle
`timescale 1ns/1ps

module wb_arbiter #(
  parameter int ADDR_W = 11
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                m0_cyc, m0_stb, m0_we,
  input  logic [ADDR_W-1:0]   m0_adr,
  input  tbuf_pkg::data_t     m0_dat_w,
  output logic                m0_ack,
  output tbuf_pkg::data_t     m0_dat_r,
  input  logic                m1_cyc, m1_stb, m1_we,
  input  logic [ADDR_W-1:0]   m1_adr,
  input  tbuf_pkg::data_t     m1_dat_w,
  output logic                m1_ack,
  output tbuf_pkg::data_t     m1_dat_r,
  input  logic                m2_cyc, m2_stb, m2_we,
  input  logic [ADDR_W-1:0]   m2_adr,
  input  tbuf_pkg::data_t     m2_dat_w,
  output logic                m2_ack,
  output tbuf_pkg::data_t     m2_dat_r,
  output logic                s_cyc, s_stb, s_we,
  output logic [ADDR_W-1:0]   s_adr,
  output tbuf_pkg::data_t     s_dat_w,
  input  logic                s_ack,
  input  tbuf_pkg::data_t     s_dat_r
);

  logic [2:0]        m_cyc, m_stb, m_we, own;
  logic [ADDR_W-1:0] m_adr   [3];
  tbuf_pkg::data_t   m_dat_w [3];
  logic              owner_valid;
  logic [1:0]        last, next_idx;

  assign m_cyc   = {m2_cyc, m1_cyc, m0_cyc};
  assign m_stb   = {m2_stb, m1_stb, m0_stb};
  assign m_we    = {m2_we, m1_we, m0_we};
  assign m_adr   = '{m0_adr, m1_adr, m2_adr};
  assign m_dat_w = '{m0_dat_w, m1_dat_w, m2_dat_w};

  // Search starts at the master after the last owner
  always_comb begin
    int idx;
    next_idx = last;
    for (int i = 3; i >= 1; i--) begin
      idx = (int'(last) + i) % 3;
      if (m_cyc[idx]) next_idx = 2'(idx);
    end
  end

  // Owner is kept while its cyc is held, last doubles as the current owner
  always_ff @(posedge clk) begin
    if (rst) begin
      owner_valid <= 1'b0;
      last        <= 2'd2;
    end else if (!owner_valid || !m_cyc[last]) begin
      owner_valid <= |m_cyc;
      if (|m_cyc) last <= next_idx;
    end
  end

  assign own = owner_valid ? (3'b001 << last) : 3'b000;

  assign s_cyc   = |(own & m_cyc);
  assign s_stb   = |(own & m_stb);
  assign s_we    = |(own & m_we);
  assign s_adr   = m_adr[last];
  assign s_dat_w = m_dat_w[last];

  assign m0_ack   = own[0] && s_ack;
  assign m1_ack   = own[1] && s_ack;
  assign m2_ack   = own[2] && s_ack;
  assign m0_dat_r = own[0] ? s_dat_r : '0;
  assign m1_dat_r = own[1] ? s_dat_r : '0;
  assign m2_dat_r = own[2] ? s_dat_r : '0;

endmodule

// File: wb_ram.sv
// Single-port word memory behind a Wishbone classic slave with registered ack
`timescale 1ns/1ps

module wb_ram #(
  parameter int ADDR_W = 11
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                cyc,
  input  logic                stb,
  input  logic                we,
  input  logic [ADDR_W-1:0]   adr,
  input  tbuf_pkg::data_t     dat_w,
  output logic                ack,
  output tbuf_pkg::data_t     dat_r
);

  tbuf_pkg::data_t mem [1 << ADDR_W];
  logic            access;

  // New request seen while ack is low
  assign access = cyc && stb && !ack;

  always_ff @(posedge clk) begin
    if (rst) ack <= 1'b0;
    else     ack <= access;
  end

  // Write lands and read data loads on the edge that raises ack
  always_ff @(posedge clk) begin
    if (access && we) mem[adr] <= dat_w;
    if (access)       dat_r    <= mem[adr];
  end

endmodule

// File: tbuf_top.sv
// Top level joining store and load ports, CAM, Wishbone arbiter and memory
`timescale 1ns/1ps

module tbuf_top #(
  parameter int ADDR_W    = 11,
  parameter int BUF_COUNT = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                except,
  input  tbuf_pkg::thread_t   except_thread,
  input  logic                st_req,
  input  logic [ADDR_W-1:0]   st_addr,
  input  tbuf_pkg::data_t     st_data,
  input  tbuf_pkg::thread_t   st_thread,
  output logic                st_busy,
  output logic                st_done,
  output logic                st_full,
  input  logic                ld0_req,
  input  logic [ADDR_W-1:0]   ld0_addr,
  output logic                ld0_busy,
  output logic                ld0_done,
  output logic                ld0_replay,
  output tbuf_pkg::data_t     ld0_data,
  input  logic                ld1_req,
  input  logic [ADDR_W-1:0]   ld1_addr,
  output logic                ld1_busy,
  output logic                ld1_done,
  output logic                ld1_replay,
  output tbuf_pkg::data_t     ld1_data
);

  logic [ADDR_W-1:0] cam_new_addr, chk_addr0, chk_addr1;
  tbuf_pkg::thread_t cam_new_thread;
  logic              cam_new_en, cam_free, chk_match0, chk_match1;

  // Wishbone, m0 store, m1 load 0, m2 load 1, s memory
  logic              m0_cyc, m0_stb, m0_we, m0_ack;
  logic              m1_cyc, m1_stb, m1_we, m1_ack;
  logic              m2_cyc, m2_stb, m2_we, m2_ack;
  logic              s_cyc, s_stb, s_we, s_ack;
  logic [ADDR_W-1:0] m0_adr, m1_adr, m2_adr, s_adr;
  tbuf_pkg::data_t   m0_dat_w, m1_dat_r, m2_dat_r, s_dat_w, s_dat_r;

  store_port #(.ADDR_W(ADDR_W)) u_store (
    .clk, .rst, .st_req, .st_addr, .st_data, .st_thread, .cam_free,
    .wb_ack(m0_ack), .st_busy, .st_done, .st_full,
    .cam_new_addr, .cam_new_thread, .cam_new_en,
    .wb_cyc(m0_cyc), .wb_stb(m0_stb), .wb_we(m0_we), .wb_adr(m0_adr), .wb_dat_w(m0_dat_w)
  );

  load_port #(.ADDR_W(ADDR_W)) u_load0 (
    .clk, .rst, .ld_req(ld0_req), .ld_addr(ld0_addr), .chk_match(chk_match0),
    .wb_ack(m1_ack), .wb_dat_r(m1_dat_r), .ld_busy(ld0_busy), .ld_done(ld0_done),
    .ld_replay(ld0_replay), .ld_data(ld0_data), .chk_addr(chk_addr0),
    .wb_cyc(m1_cyc), .wb_stb(m1_stb), .wb_we(m1_we), .wb_adr(m1_adr)
  );

  load_port #(.ADDR_W(ADDR_W)) u_load1 (
    .clk, .rst, .ld_req(ld1_req), .ld_addr(ld1_addr), .chk_match(chk_match1),
    .wb_ack(m2_ack), .wb_dat_r(m2_dat_r), .ld_busy(ld1_busy), .ld_done(ld1_done),
    .ld_replay(ld1_replay), .ld_data(ld1_data), .chk_addr(chk_addr1),
    .wb_cyc(m2_cyc), .wb_stb(m2_stb), .wb_we(m2_we), .wb_adr(m2_adr)
  );

  tbufcam #(.ADDR_W(ADDR_W), .BUF_COUNT(BUF_COUNT)) u_cam (
    .clk, .rst, .except, .except_thread,
    .new_addr(cam_new_addr), .new_thread(cam_new_thread), .new_en(cam_new_en),
    .chk_addr0, .chk_addr1, .chk_match0, .chk_match1, .free(cam_free)
  );

  // Loads never write, store never reads
  wb_arbiter #(.ADDR_W(ADDR_W)) u_arb (
    .clk, .rst,
    .m0_cyc, .m0_stb, .m0_we, .m0_adr, .m0_dat_w, .m0_ack, .m0_dat_r(),
    .m1_cyc, .m1_stb, .m1_we, .m1_adr, .m1_dat_w('0), .m1_ack, .m1_dat_r,
    .m2_cyc, .m2_stb, .m2_we, .m2_adr, .m2_dat_w('0), .m2_ack, .m2_dat_r,
    .s_cyc, .s_stb, .s_we, .s_adr, .s_dat_w, .s_ack, .s_dat_r
  );

  wb_ram #(.ADDR_W(ADDR_W)) u_ram (
    .clk, .rst, .cyc(s_cyc), .stb(s_stb), .we(s_we), .adr(s_adr),
    .dat_w(s_dat_w), .ack(s_ack), .dat_r(s_dat_r)
  );

endmodule

// File: tbuf_top_tb.sv
// Testbench for tbuf_top with memory and CAM reference model, directed and random tests
`timescale 1ns/1ps

module tbuf_top_tb;

  localparam int ADDR_W     = 11;
  localparam int BUF_COUNT  = 4;
  localparam int WAIT_LIMIT = 50;
  localparam int RAND_OPS   = 200;

  typedef logic [ADDR_W-1:0] addr_t;

  logic              clk = 1'b0;
  logic              rst;
  logic              except;
  tbuf_pkg::thread_t except_thread;
  logic              st_req, st_busy, st_done, st_full;
  addr_t             st_addr;
  tbuf_pkg::data_t   st_data;
  tbuf_pkg::thread_t st_thread;
  logic              ld0_req, ld0_busy, ld0_done, ld0_replay;
  logic              ld1_req, ld1_busy, ld1_done, ld1_replay;
  addr_t             ld0_addr, ld1_addr;
  tbuf_pkg::data_t   ld0_data, ld1_data;

  // Shadow memory and live CAM addresses per thread
  tbuf_pkg::data_t shadow_mem   [1 << ADDR_W];
  bit              shadow_valid [1 << ADDR_W];
  addr_t           valid_list   [$];
  addr_t           live_addr    [2][BUF_COUNT];
  int              live_cnt     [2];

  // Expected results in request order for the compare process
  logic        exp_st  [$];
  logic [32:0] exp_ld0 [$];
  logic [32:0] exp_ld1 [$];
  int rd_st = 0;
  int rd_ld0 = 0;
  int rd_ld1 = 0;

  int seq_checks = 0;
  int seq_errors = 0;
  int cmp_checks = 0;
  int cmp_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int test_err_base = 0;

  tbuf_top #(.ADDR_W(ADDR_W), .BUF_COUNT(BUF_COUNT)) u_dut (
    .clk, .rst, .except, .except_thread,
    .st_req, .st_addr, .st_data, .st_thread, .st_busy, .st_done, .st_full,
    .ld0_req, .ld0_addr, .ld0_busy, .ld0_done, .ld0_replay, .ld0_data,
    .ld1_req, .ld1_addr, .ld1_busy, .ld1_done, .ld1_replay, .ld1_data
  );

  always #5 clk = ~clk;

  // Expected {replay, data} of a load from address a
  function automatic logic [32:0] ref_load(input addr_t a);
    logic hit;
    hit = 1'b0;
    // Any live entry of either thread forces a replay
    for (int t = 0; t < 2; t++) begin
      for (int k = 0; k < live_cnt[t]; k++) begin
        if (live_addr[t][k] == a) hit = 1'b1;
      end
    end
    if (hit) return {1'b1, 32'h0};
    return {1'b0, shadow_mem[a]};
  endfunction

  task automatic check_load(input int port, input logic replay, input tbuf_pkg::data_t data,
                            input logic [32:0] e);
    cmp_checks += 2;
    assert (replay === e[32]) else begin
      $display("[FAIL] ld%0d_replay got %h expected %h", port, replay, e[32]);
      cmp_errors++;
    end
    assert (data === e[31:0]) else begin
      $display("[FAIL] ld%0d_data got %h expected %h", port, data, e[31:0]);
      cmp_errors++;
    end
  endtask

  // Results are stable at the falling edge of a done cycle
  always @(negedge clk) begin
    if (!rst && st_done && rd_st >= exp_st.size()) begin
      $display("Store port raised done with no store outstanding");
      cmp_errors++;
    end else if (!rst && st_done) begin
      cmp_checks++;
      assert (st_full === exp_st[rd_st]) else begin
        $display("[FAIL] st_full got %h expected %h", st_full, exp_st[rd_st]);
        cmp_errors++;
      end
      rd_st++;
    end
    if (!rst && ld0_done && rd_ld0 >= exp_ld0.size()) begin
      $display("Load port 0 raised done with no load outstanding");
      cmp_errors++;
    end else if (!rst && ld0_done) begin
      check_load(0, ld0_replay, ld0_data, exp_ld0[rd_ld0]);
      rd_ld0++;
    end
    if (!rst && ld1_done && rd_ld1 >= exp_ld1.size()) begin
      $display("Load port 1 raised done with no load outstanding");
      cmp_errors++;
    end else if (!rst && ld1_done) begin
      check_load(1, ld1_replay, ld1_data, exp_ld1[rd_ld1]);
      rd_ld1++;
    end
  end

  task automatic end_run();
    $display("Tests run %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
             seq_checks + cmp_checks, seq_errors + cmp_errors);
    if (seq_errors + cmp_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = seq_errors + cmp_errors - test_err_base;
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("Test %0d %0s: %0s, %0d errors", tests_run, name, (errs == 0) ? "pass" : "fail",
             errs);
    test_err_base = seq_errors + cmp_errors;
  endtask

  task automatic check_level(input string name, input logic value, input logic expected);
    seq_checks++;
    assert (value === expected) else begin
      $display("[FAIL] %0s got %h expected %h", name, value, expected);
      seq_errors++;
    end
  endtask

  // Model is updated at request time
  task automatic start_store(input addr_t a, input tbuf_pkg::data_t d,
                             input tbuf_pkg::thread_t t);
    logic full;
    full = (live_cnt[t] == BUF_COUNT);
    exp_st.push_back(full);
    // A full bank neither writes memory nor allocates
    if (!full) begin
      shadow_mem[a] = d;
      if (!shadow_valid[a]) valid_list.push_back(a);
      shadow_valid[a] = 1'b1;
      live_addr[t][live_cnt[t]] = a;
      live_cnt[t]++;
    end
    st_addr   = a;
    st_data   = d;
    st_thread = t;
    st_req    = 1'b1;
  endtask

  task automatic start_load(input int port, input addr_t a);
    if (port == 0) begin
      exp_ld0.push_back(ref_load(a));
      ld0_addr = a;
      ld0_req  = 1'b1;
    end else begin
      exp_ld1.push_back(ref_load(a));
      ld1_addr = a;
      ld1_req  = 1'b1;
    end
  endtask

  // One edge samples the pending requests
  task automatic issue();
    @(posedge clk);
    #1;
    st_req  = 1'b0;
    ld0_req = 1'b0;
    ld1_req = 1'b0;
    except  = 1'b0;
  endtask

  // Mask bit 0 selects the store port and bits 1 and 2 the load ports
  task automatic wait_all(input logic [2:0] mask);
    logic [2:0] seen;
    int cycles;
    seen = 3'b000;
    cycles = 0;
    while ((seen & mask) != mask) begin
      @(negedge clk);
      // Busy holds from acceptance through the done cycle
      if (mask[0] && !seen[0]) check_level("st_busy", st_busy, 1'b1);
      if (mask[1] && !seen[1]) check_level("ld0_busy", ld0_busy, 1'b1);
      if (mask[2] && !seen[2]) check_level("ld1_busy", ld1_busy, 1'b1);
      seen = seen | {ld1_done, ld0_done, st_done};
      cycles++;
      if ((seen & mask) != mask && cycles >= WAIT_LIMIT) begin
        $display("Timeout after %0d cycles waiting for done on ports %b", cycles, mask & ~seen);
        seq_errors++;
        end_run();
      end
    end
    @(posedge clk);
    #1;
    if (mask[0]) check_level("st_busy", st_busy, 1'b0);
    if (mask[1]) check_level("ld0_busy", ld0_busy, 1'b0);
    if (mask[2]) check_level("ld1_busy", ld1_busy, 1'b0);
  endtask

  task automatic do_store(input addr_t a, input tbuf_pkg::data_t d, input tbuf_pkg::thread_t t);
    start_store(a, d, t);
    issue();
    wait_all(3'b001);
  endtask

  task automatic do_load(input int port, input addr_t a);
    start_load(port, a);
    issue();
    wait_all((port == 0) ? 3'b010 : 3'b100);
  endtask

  task automatic flush(input tbuf_pkg::thread_t t);
    except        = 1'b1;
    except_thread = t;
    live_cnt[t]   = 0;
    issue();
  endtask

  initial begin
    int op;
    addr_t a;
    void'($urandom(32'he427b1f7));
    rst = 1'b1;
    except = 1'b0;
    except_thread = '0;
    st_req = 1'b0;
    st_addr = '0;
    st_data = '0;
    st_thread = '0;
    ld0_req = 1'b0;
    ld0_addr = '0;
    ld1_req = 1'b0;
    ld1_addr = '0;
    live_cnt[0] = 0;
    live_cnt[1] = 0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    check_level("st_busy", st_busy, 1'b0);
    check_level("st_done", st_done, 1'b0);
    check_level("ld0_busy", ld0_busy, 1'b0);
    check_level("ld0_done", ld0_done, 1'b0);
    check_level("ld1_busy", ld1_busy, 1'b0);
    check_level("ld1_done", ld1_done, 1'b0);
    do_store(11'h010, 32'h1234_5678, 1'b0);
    end_test("reset and first store");

    do_store(11'h020, 32'hcafe_0001, 1'b1);
    do_load(0, 11'h010);
    do_load(1, 11'h010);
    do_load(0, 11'h020);
    do_load(1, 11'h020);
    end_test("replay on live stores");

    flush(1'b0);
    do_load(0, 11'h010);
    do_load(1, 11'h020);
    do_load(1, 11'h010);
    end_test("flush by exception");

    for (int k = 0; k < BUF_COUNT; k++) begin
      do_store(addr_t'(11'h100 + k), tbuf_pkg::data_t'($urandom()), 1'b0);
    end
    // Bank of thread 0 is full here
    do_store(11'h100, 32'hdead_beef, 1'b0);
    do_store(11'h200, 32'h0bad_f00d, 1'b1);
    flush(1'b0);
    do_load(0, 11'h100);
    do_load(1, 11'h200);
    end_test("full bank");

    start_store(11'h300, 32'h5a5a_0300, 1'b1);
    start_load(0, 11'h010);
    start_load(1, 11'h100);
    issue();
    wait_all(3'b111);
    end_test("concurrent loads and store");

    for (int i = 0; i < RAND_OPS; i++) begin
      op = $urandom_range(9);
      if (op == 9) begin
        flush(tbuf_pkg::thread_t'($urandom_range(1)));
      end else if (op >= 4 && valid_list.size() > 0) begin
        a = valid_list[$urandom_range(valid_list.size() - 1)];
        do_load($urandom_range(1), a);
      end else begin
        do_store(addr_t'($urandom_range(63)), tbuf_pkg::data_t'($urandom()),
                 tbuf_pkg::thread_t'($urandom_range(1)));
      end
    end
    end_test("random sequence");

    end_run();
  end

endmodule

// File: tbuf_top.f
tbuf_pkg.sv
tbufcam_entry.sv
find_first_set.sv
tbufcam.sv
store_port.sv
load_port.sv
wb_arbiter.sv
wb_ram.sv
tbuf_top.sv
tbuf_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build tbuf_top_tb with Verilator, run it and check the log for failure
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tbuf_top_tb -f tbuf_top.f -o tbuf_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tbuf_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
  echo "Simulation reported failures"
  exit 1
fi

exit 0
